/* cam_alloc.sv */
module cam_alloc #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries,
  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1
) (
  input  logic             clk,
  input  logic             rst_an,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  logic             fl_not_empty,
  input  logic [idx_w-1:0] fl_head,
  output logic             fl_pop,
  output logic             wr_en,
  output logic [idx_w-1:0] wr_index
);

  logic [idx_w-1:0] fresh_cnt;
  logic             used_all;

  // fresh locations are handed out in ascending order until each has been used once.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      fresh_cnt <= '0;
      used_all  <= 1'b0;
    end else if (wr_en && !used_all) begin
      if (fresh_cnt == idx_w'(n_entries - 1)) begin
        used_all <= 1'b1;
      end else begin
        fresh_cnt <= fresh_cnt + 1'b1;
      end
    end
  end

  // after that only recycled locations are available.
  assign wr_ready = used_all ? fl_not_empty : 1'b1;
  assign wr_en    = wr_valid & wr_ready;
  assign wr_index = used_all ? fl_head : fresh_cnt;
  assign fl_pop   = wr_en & used_all;

endmodule

/* cam_cfg_pkg.sv */
package cam_cfg_pkg;

  // the low byte of every stored word is the search key.
  localparam int cam_key_w = 8;

  // full width of a stored word, key included.
  localparam int cam_data_w = 16;

  // bits of a word that sit above the key.
  localparam int cam_payload_w = cam_data_w - cam_key_w;

  // depth used when the top level is not given one.
  localparam int cam_default_entries = 110;

endpackage

/* cam_free_list.sv */
module cam_free_list #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries,
  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1
) (
  input  logic             clk,
  input  logic             rst_an,
  input  logic             push,
  input  logic [idx_w-1:0] push_index,
  input  logic             pop,
  output logic             not_empty,
  output logic [idx_w-1:0] head
);

  localparam int cnt_w = $clog2(n_entries + 1);

  logic [idx_w-1:0] mem [n_entries];
  logic [idx_w-1:0] rd_ptr;
  logic [idx_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;

  // the buffer depth need not be a power of two, so pointers wrap explicitly.
  function automatic logic [idx_w-1:0] next_ptr(input logic [idx_w-1:0] ptr);
    if (ptr == idx_w'(n_entries - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_index;
    end
  end

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a pushed index shows up at the head from the cycle after its edge.
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

endmodule

/* cam_search.sv */
module cam_search #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries,
  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1
) (
  input  logic [cam_cfg_pkg::cam_key_w-1:0] key,
  input  cam_types_pkg::cam_entry_t          entries [n_entries],
  input  logic [n_entries-1:0]              valid,
  output cam_types_pkg::cam_result_t         result,
  output logic [idx_w-1:0]                  hit_index
);

  logic [n_entries-1:0] match;

  // every valid entry is compared in parallel.
  always_comb begin
    for (int i = 0; i < n_entries; i++) begin
      match[i] = valid[i] && (entries[i].key == key);
    end
  end

  // scanning downwards leaves the lowest matching index as the final choice.
  always_comb begin
    result.hit   = |match;
    result.entry = '0;
    hit_index    = '0;
    for (int i = n_entries - 1; i >= 0; i--) begin
      if (match[i]) begin
        result.entry = entries[i];
        hit_index    = idx_w'(i);
      end
    end
  end

endmodule

/* cam_store.sv */
module cam_store #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries,
  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1
) (
  input  logic                     clk,
  input  logic                     rst_an,
  input  logic                     wr_en,
  input  logic [idx_w-1:0]         wr_index,
  input  cam_types_pkg::cam_entry_t wr_entry,
  input  logic                     clr_en,
  input  logic [idx_w-1:0]         clr_index,
  output cam_types_pkg::cam_entry_t entries [n_entries],
  output logic [n_entries-1:0]     valid
);

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      for (int i = 0; i < n_entries; i++) begin
        entries[i] <= '0;
      end
    end else begin
      for (int i = 0; i < n_entries; i++) begin
        if (wr_en && wr_index == idx_w'(i)) begin
          entries[i] <= wr_entry;
        end
      end
    end
  end

  // the write target is never a valid entry, so a write and a clear never meet.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      valid <= '0;
    end else begin
      for (int i = 0; i < n_entries; i++) begin
        if (clr_en && clr_index == idx_w'(i)) begin
          valid[i] <= 1'b0;
        end
        if (wr_en && wr_index == idx_w'(i)) begin
          valid[i] <= 1'b1;
        end
      end
    end
  end

endmodule

/* cam_top.sv */
module cam_top #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries
) (
  input  logic                       clk,
  input  logic                       rst_an,
  input  cam_types_pkg::cam_write_t  wr,
  output logic                       wr_ready,
  input  cam_types_pkg::cam_snoop_t  snoop,
  output cam_types_pkg::cam_result_t result
);

  import cam_types_pkg::*;

  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1;

  logic                 wr_en;
  logic [idx_w-1:0]     wr_index;
  logic                 fl_not_empty;
  logic [idx_w-1:0]     fl_head;
  logic                 fl_pop;
  cam_entry_t           entries [n_entries];
  logic [n_entries-1:0] valid;
  logic [idx_w-1:0]     hit_index;
  logic                 free_en;

  cam_alloc #(
    .n_entries(n_entries)
  ) u_alloc (
    .clk         (clk),
    .rst_an      (rst_an),
    .wr_valid    (wr.valid),
    .wr_ready    (wr_ready),
    .fl_not_empty(fl_not_empty),
    .fl_head     (fl_head),
    .fl_pop      (fl_pop),
    .wr_en       (wr_en),
    .wr_index    (wr_index)
  );

  cam_free_list #(
    .n_entries(n_entries)
  ) u_free_list (
    .clk       (clk),
    .rst_an    (rst_an),
    .push      (free_en),
    .push_index(hit_index),
    .pop       (fl_pop),
    .not_empty (fl_not_empty),
    .head      (fl_head)
  );

  cam_store #(
    .n_entries(n_entries)
  ) u_store (
    .clk      (clk),
    .rst_an   (rst_an),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_entry (wr.entry),
    .clr_en   (free_en),
    .clr_index(hit_index),
    .entries  (entries),
    .valid    (valid)
  );

  cam_search #(
    .n_entries(n_entries)
  ) u_search (
    .key      (snoop.key),
    .entries  (entries),
    .valid    (valid),
    .result   (result),
    .hit_index(hit_index)
  );

  // a real snoop hit frees its entry and recycles the location in the same edge.
  assign free_en = snoop.valid & result.hit;

endmodule

/* cam_top_sva.sv */
module cam_top_sva #(
  parameter int n_entries = cam_cfg_pkg::cam_default_entries,
  localparam int idx_w = (n_entries > 1) ? $clog2(n_entries) : 1,
  localparam int cnt_w = $clog2(n_entries + 1)
) (
  input logic                 clk,
  input logic                 rst_an,
  input logic                 wr_ready,
  input logic                 wr_en,
  input logic [idx_w-1:0]     wr_index,
  input logic                 free_en,
  input logic [cnt_w-1:0]     fl_count,
  input logic [n_entries-1:0] valid
);

  // only valid entries can be freed, so the free list never runs over.
  push_not_full: assert property (@(posedge clk) disable iff (!rst_an)
    free_en |-> fl_count != cnt_w'(n_entries))
    else $error("free list pushed while full");

  // a pop from an empty list would wrap the occupancy count past the depth.
  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_an)
    fl_count <= cnt_w'(n_entries))
    else $error("free list count out of range after a pop while empty");

  // a write must never land on an entry that still holds live data.
  write_target_free: assert property (@(posedge clk) disable iff (!rst_an)
    wr_en |-> !valid[wr_index])
    else $error("write targets a valid entry");

  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_an) |-> wr_ready)
    else $error("write ready low right after reset");

endmodule

bind cam_top cam_top_sva #(
  .n_entries(n_entries)
) u_sva (
  .clk         (clk),
  .rst_an      (rst_an),
  .wr_ready    (wr_ready),
  .wr_en       (wr_en),
  .wr_index    (wr_index),
  .free_en     (free_en),
  .fl_count    (u_free_list.count),
  .valid       (valid)
);

/* cam_types_pkg.sv */
package cam_types_pkg;

  // one stored word; the key occupies the low bits.
  typedef struct packed {
    logic [cam_cfg_pkg::cam_payload_w-1:0] payload;
    logic [cam_cfg_pkg::cam_key_w-1:0]     key;
  } cam_entry_t;

  // write request, accepted when valid and ready are both high.
  typedef struct packed {
    logic       valid;
    cam_entry_t entry;
  } cam_write_t;

  // snoop request; a plain strobe without back-pressure.
  typedef struct packed {
    logic                              valid;
    logic [cam_cfg_pkg::cam_key_w-1:0] key;
  } cam_snoop_t;

  // snoop answer. The entry is zero on a miss.
  typedef struct packed {
    logic       hit;
    cam_entry_t entry;
  } cam_result_t;

endpackage

/* project.f */
cam_cfg_pkg.sv
cam_types_pkg.sv
cam_alloc.sv
cam_free_list.sv
cam_store.sv
cam_search.sv
cam_top.sv
cam_top_sva.sv
tb_cam.sv

/* run.sh */
#!/bin/sh
# Compile and run the CAM testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cam \
  -f project.f -o tb_cam \
  && ./obj_dir/tb_cam \
  || exit 1

/* tb_cam.sv */
module tb_cam;

  import cam_cfg_pkg::*;
  import cam_types_pkg::*;

  localparam int n_entries = 12;
  localparam int clk_period = 8;
  localparam int reset_cycles = 10;
  localparam int directed_cycles = 40;
  localparam int random_cycles = 4000;
  localparam int total_cycles = reset_cycles + directed_cycles + random_cycles;
  localparam int timeout_time = 2 * total_cycles * clk_period + 100;

  logic        clk;
  logic        rst_an;
  cam_write_t  wr;
  logic        wr_ready;
  cam_snoop_t  snoop;
  cam_result_t result;

  // reference model state.
  cam_entry_t m_entry [n_entries];
  logic       m_valid [n_entries];
  int         m_fresh;
  int         m_free_q[$];

  // outputs as seen at the last check point.
  logic       seen_ready;
  logic       seen_hit;
  cam_entry_t seen_word;

  cam_top #(
    .n_entries(n_entries)
  ) UUT (
    .clk     (clk),
    .rst_an  (rst_an),
    .wr      (wr),
    .wr_ready(wr_ready),
    .snoop   (snoop),
    .result  (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_time);
    $display("timeout: the test did not finish in the expected number of cycles");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic model_ready();
    return (m_fresh < n_entries) || (m_free_q.size() > 0);
  endfunction

  // the lowest valid index with a matching key wins.
  function automatic void model_lookup(input logic [cam_key_w-1:0] key, output logic hit,
                                       output cam_entry_t word, output int idx);
    hit  = 1'b0;
    word = '0;
    idx  = 0;
    for (int i = 0; i < n_entries; i++) begin
      if (!hit && m_valid[i] && m_entry[i].key == key) begin
        hit  = 1'b1;
        word = m_entry[i];
        idx  = i;
      end
    end
  endfunction

  // one clock cycle, entered and left just after a falling edge.
  task automatic drive_cycle(input logic wr_valid, input cam_entry_t wr_word,
                             input logic snoop_valid, input logic [cam_key_w-1:0] key);
    logic       exp_ready;
    logic       exp_hit;
    cam_entry_t exp_word;
    int         hit_idx;
    int         wr_idx;
    logic       take_write;
    logic       take_clear;
    wr.valid    = wr_valid;
    wr.entry    = wr_word;
    snoop.valid = snoop_valid;
    snoop.key   = key;
    #1;
    exp_ready = model_ready();
    model_lookup(key, exp_hit, exp_word, hit_idx);
    compare_value("wr_ready", 32'(exp_ready), 32'(wr_ready));
    compare_value("result.hit", 32'(exp_hit), 32'(result.hit));
    compare_value("result.entry", 32'(exp_word), 32'(result.entry));
    seen_ready = wr_ready;
    seen_hit   = result.hit;
    seen_word  = result.entry;
    take_write = wr_valid && exp_ready;
    take_clear = snoop_valid && exp_hit;
    wr_idx = (m_fresh < n_entries) ? m_fresh : ((m_free_q.size() > 0) ? m_free_q[0] : 0);
    @(posedge clk);
    if (take_clear) begin
      m_valid[hit_idx] = 1'b0;
      m_free_q.push_back(hit_idx);
    end
    if (take_write) begin
      m_entry[wr_idx] = wr_word;
      m_valid[wr_idx] = 1'b1;
      if (m_fresh < n_entries) begin
        m_fresh++;
      end else begin
        void'(m_free_q.pop_front());
      end
    end
    @(negedge clk);
  endtask

  task automatic write_word(input logic [15:0] word);
    drive_cycle(1'b1, word, 1'b0, '0);
  endtask

  // a snoop key with valid low shows the match without freeing it.
  task automatic peek_key(input logic [cam_key_w-1:0] key);
    drive_cycle(1'b0, '0, 1'b0, key);
  endtask

  task automatic snoop_key(input logic [cam_key_w-1:0] key);
    drive_cycle(1'b0, '0, 1'b1, key);
  endtask

  initial begin
    cam_entry_t word;
    void'($urandom(32'h12de0c4a));
    rst_an  = 1'b0;
    wr      = '0;
    snoop   = '0;
    m_fresh = 0;
    for (int i = 0; i < n_entries; i++) begin
      m_entry[i] = '0;
      m_valid[i] = 1'b0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_an = 1'b1;

    // an empty store misses on every key, key zero included.
    peek_key(8'h00);
    compare_value("wr_ready", 32'd1, 32'(seen_ready));
    compare_value("result.hit", 32'd0, 32'(seen_hit));
    snoop_key(8'h5a);
    compare_value("result.entry", 32'd0, 32'(seen_word));

    // three words share key 05 at indices 0, 1 and 2.
    write_word(16'ha105);
    peek_key(8'h05);
    compare_value("result.entry", 32'h0000a105, 32'(seen_word));
    write_word(16'hb205);
    write_word(16'hc305);
    snoop_key(8'h05);
    compare_value("result.entry", 32'h0000a105, 32'(seen_word));
    snoop_key(8'h05);
    compare_value("result.entry", 32'h0000b205, 32'(seen_word));
    snoop_key(8'h05);
    compare_value("result.entry", 32'h0000c305, 32'(seen_word));
    snoop_key(8'h05);
    compare_value("result.hit", 32'd0, 32'(seen_hit));

    // nine fresh locations, then the three freed ones, leave the store full.
    for (int i = 0; i < n_entries; i++) begin
      write_word({8'(i), 8'(8'h10 + i)});
    end
    peek_key(8'h13);
    compare_value("wr_ready", 32'd0, 32'(seen_ready));
    write_word(16'hee13);
    snoop_key(8'h13);
    compare_value("result.entry", 32'h00000313, 32'(seen_word));
    write_word(16'h7720);
    compare_value("wr_ready", 32'd1, 32'(seen_ready));
    peek_key(8'h20);
    compare_value("wr_ready", 32'd0, 32'(seen_ready));
    compare_value("result.entry", 32'h00007720, 32'(seen_word));

    // random mix over a small key range.
    for (int n = 0; n < random_cycles; n++) begin
      word.payload = 8'($urandom);
      word.key     = 8'($urandom_range(0, 7));
      drive_cycle($urandom_range(0, 99) < 55, word, $urandom_range(0, 99) < 40,
                  8'($urandom_range(0, 7)));
    end

    $display("sim passed");
    $finish;
  end

endmodule
